// File: logic/pipePkg.sv
// pipeline shared definitions
// word and register types, command encoding, forwarding selects
// and the bit positions of the instruction fields
package pipePkg;

	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;
	typedef logic [31:0] instrT;

	// command field encoding
	typedef enum logic [1:0] {
		cmdPlain = 2'b00,
		cmdJump  = 2'b01,
		cmdStore = 2'b10,
		cmdLoad  = 2'b11
	} cmdT;

	// operand source for execute
	typedef enum logic [1:0] {
		fwdNone,
		fwdMem,
		fwdWb
	} fwdSelT;

	localparam wordT pcResetValue = '0;

	////////////////////
	// instruction fields
	localparam int cmdMsb = 31;
	localparam int cmdLsb = 30;
	localparam int rdMsb = 29;
	localparam int rdLsb = 25;
	localparam int rs1Msb = 24;
	localparam int rs1Lsb = 20;
	localparam int rs2Msb = 19;
	localparam int rs2Lsb = 15;
	localparam int immMsb = 14;
	localparam int immLsb = 0;
	localparam int immWidth = 15;

endpackage

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
// pipeline hazard control
// picks forwarding sources for execute, inserts the load-use bubble,
// stalls on outstanding fetch and data transfers and flushes decode
// behind a taken jump
module hazardUnit (
	input  logic clk,
	input  logic reset,
	input  pipePkg::cmdT cmdD,
	input  pipePkg::regAddrT rs1D,
	input  pipePkg::regAddrT rs2D,
	input  pipePkg::cmdT cmdE,
	input  pipePkg::regAddrT rdE,
	input  pipePkg::regAddrT rs1E,
	input  pipePkg::regAddrT rs2E,
	input  pipePkg::cmdT cmdM,
	input  pipePkg::regAddrT rdM,
	input  logic weM,
	input  pipePkg::regAddrT rdW,
	input  logic weW,
	input  logic jumpTaken,
	input  logic fetchPending,
	input  logic dataPending,
	input  logic dataAck,
	output pipePkg::fwdSelT fwdA,
	output pipePkg::fwdSelT fwdB,
	output logic stallAll,
	output logic bubbleE,
	output logic flushD
);

	typedef enum logic {
		idle,
		loadWait
	} loadStateT;

	loadStateT state;
	loadStateT stateNext;
	logic loadInM;
	logic loadStall;
	logic storeStall;
	logic fetchStall;
	logic useRs2;
	logic loadUse;

	// M wins over W and register zero never forwards
	function automatic pipePkg::fwdSelT pickFwd(input pipePkg::regAddrT src);
		pipePkg::fwdSelT sel;
		sel = pipePkg::fwdNone;
		if (src != '0 && src == rdM && weM) begin
			sel = pipePkg::fwdMem;
		end else if (src != '0 && src == rdW && weW) begin
			sel = pipePkg::fwdWb;
		end
		return sel;
	endfunction

	assign fwdA = pickFwd(rs1E);
	assign fwdB = pickFwd(rs2E);

	////////////////////
	// load wait FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= stateNext;
		end
	end

	assign loadInM = (cmdM == pipePkg::cmdLoad) && dataPending;

	always_comb begin
		stateNext = state;
		case (state)
			idle: begin
				if (loadInM && !dataAck) begin
					stateNext = loadWait;
				end
			end
			loadWait: begin
				if (dataAck) begin
					stateNext = idle;
				end
			end
			default: begin
				stateNext = idle;
			end
		endcase
	end

	////////////////////
	// stalls
	assign fetchStall = fetchPending;
	assign loadStall = (state == idle) ? (loadInM && !dataAck) : !dataAck;
	assign storeStall = (cmdM == pipePkg::cmdStore) && dataPending && !dataAck;
	assign stallAll = fetchStall || loadStall || storeStall;

	////////////////////
	// load-use bubble and jump flush
	// jump and load never read rs2
	assign useRs2 = (cmdD == pipePkg::cmdPlain) || (cmdD == pipePkg::cmdStore);
	assign loadUse = (cmdE == pipePkg::cmdLoad) && (rdE != '0)
		&& ((rdE == rs1D) || (useRs2 && (rdE == rs2D)));

	// flush beats bubble
	assign bubbleE = loadUse && !jumpTaken;
	assign flushD = jumpTaken;

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps
// integer register file
// 32 entries, two combinational read ports and one write port,
// register zero stays zero and a read during a write sees the new value
module regFile #(
	parameter int DataWidth = 32
) (
	input  logic clk,
	input  logic reset,
	input  pipePkg::regAddrT rdAddrA,
	input  pipePkg::regAddrT rdAddrB,
	output pipePkg::wordT rdDataA,
	output pipePkg::wordT rdDataB,
	input  logic wrEn,
	input  pipePkg::regAddrT wrAddr,
	input  pipePkg::wordT wrData
);

	logic [DataWidth-1:0] regs [32];
	logic wrLive;

	// writes to register zero are dropped
	assign wrLive = wrEn && (wrAddr != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through on both ports
	assign rdDataA = (wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// File: logic/fetchDecode.sv
`timescale 1ns/1ps
// fetch and decode stages
// keeps the pc and runs the fetch handshake, parks an instruction that
// arrives while decode is held, splits the fields, reads the registers
// and loads the decode/execute stage register
module fetchDecode (
	input  logic clk,
	input  logic reset,
	output logic fetchValid,
	output pipePkg::wordT fetchAddr,
	input  logic fetchAck,
	input  pipePkg::instrT fetchInstr,
	input  logic stallAll,
	input  logic bubbleE,
	input  logic flushD,
	input  logic jumpTaken,
	input  pipePkg::wordT jumpTarget,
	output pipePkg::cmdT cmdD,
	output pipePkg::regAddrT rs1D,
	output pipePkg::regAddrT rs2D,
	output pipePkg::regAddrT rdD,
	output pipePkg::regAddrT rdAddrA,
	output pipePkg::regAddrT rdAddrB,
	input  pipePkg::wordT rdDataA,
	input  pipePkg::wordT rdDataB,
	output pipePkg::cmdT cmdE,
	output pipePkg::regAddrT rs1E,
	output pipePkg::regAddrT rs2E,
	output pipePkg::regAddrT rdE,
	output logic weE,
	output pipePkg::wordT opAE,
	output pipePkg::wordT opBE,
	output pipePkg::wordT immE,
	output pipePkg::wordT pcE,
	output logic fetchPending
);

	pipePkg::wordT pcF;
	logic fetchOn;
	logic fetchDone;
	logic heldValid;
	pipePkg::instrT heldInstr;
	pipePkg::wordT heldPc;
	logic validD;
	pipePkg::instrT instrD;
	pipePkg::wordT pcD;
	pipePkg::wordT immD;
	logic weD;
	logic advD;

	// no new request while a parked instruction waits
	assign fetchValid = fetchOn && !heldValid;
	assign fetchAddr = pcF;
	assign fetchPending = fetchValid && !fetchAck;
	assign fetchDone = fetchValid && fetchAck;
	assign advD = !stallAll && !bubbleE && !flushD;

	////////////////////
	// fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			fetchOn <= 1'b0;
			pcF <= pipePkg::pcResetValue;
			heldValid <= 1'b0;
		end else begin
			fetchOn <= 1'b1;
			if (jumpTaken && !stallAll) begin
				// wrong-path fetch or parked word is dropped
				pcF <= jumpTarget;
				heldValid <= 1'b0;
			end else if (fetchDone) begin
				pcF <= pcF + 32'd1;
				heldValid <= !advD;
			end else if (advD) begin
				heldValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetchDone) begin
			heldInstr <= fetchInstr;
			heldPc <= pcF;
		end
	end

	////////////////////
	// decode register
	always_ff @(posedge clk) begin
		if (reset) begin
			validD <= 1'b0;
		end else if (!stallAll && flushD) begin
			validD <= 1'b0;
		end else if (advD) begin
			validD <= heldValid || fetchDone;
		end
	end

	always_ff @(posedge clk) begin
		if (advD) begin
			instrD <= heldValid ? heldInstr : fetchInstr;
			pcD <= heldValid ? heldPc : pcF;
		end
	end

	// empty decode reads as a no-op
	always_comb begin
		cmdD = pipePkg::cmdPlain;
		rs1D = '0;
		rs2D = '0;
		rdD = '0;
		if (validD) begin
			cmdD = pipePkg::cmdT'(instrD[pipePkg::cmdMsb:pipePkg::cmdLsb]);
			rs1D = instrD[pipePkg::rs1Msb:pipePkg::rs1Lsb];
			rs2D = instrD[pipePkg::rs2Msb:pipePkg::rs2Lsb];
			rdD = instrD[pipePkg::rdMsb:pipePkg::rdLsb];
		end
	end

	assign immD = {{(pipePkg::wordWidth - pipePkg::immWidth){instrD[pipePkg::immMsb]}},
		instrD[pipePkg::immMsb:pipePkg::immLsb]};
	assign weD = (cmdD != pipePkg::cmdStore) && (rdD != '0);
	assign rdAddrA = rs1D;
	assign rdAddrB = rs2D;

	////////////////////
	// decode/execute register
	always_ff @(posedge clk) begin
		if (reset) begin
			cmdE <= pipePkg::cmdPlain;
			rs1E <= '0;
			rs2E <= '0;
			rdE <= '0;
			weE <= 1'b0;
		end else if (!stallAll) begin
			if (flushD || bubbleE) begin
				cmdE <= pipePkg::cmdPlain;
				rs1E <= '0;
				rs2E <= '0;
				rdE <= '0;
				weE <= 1'b0;
			end else begin
				cmdE <= cmdD;
				rs1E <= rs1D;
				rs2E <= rs2D;
				rdE <= rdD;
				weE <= weD;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stallAll) begin
			opAE <= rdDataA;
			opBE <= rdDataB;
			immE <= immD;
			pcE <= pcD;
		end
	end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/1ps
// execute stage
// picks forwarded operands, adds for plain, load and store,
// resolves jumps and loads the execute/memory stage register
module executeStage #(
	parameter int DataWidth = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic stallAll,
	input  pipePkg::cmdT cmdE,
	input  pipePkg::regAddrT rdE,
	input  logic weE,
	input  pipePkg::wordT opAE,
	input  pipePkg::wordT opBE,
	input  pipePkg::wordT immE,
	input  pipePkg::wordT pcE,
	input  pipePkg::fwdSelT fwdA,
	input  pipePkg::fwdSelT fwdB,
	input  pipePkg::wordT resultW,
	output logic jumpTaken,
	output pipePkg::wordT jumpTarget,
	output pipePkg::cmdT cmdM,
	output pipePkg::regAddrT rdM,
	output logic weM,
	output pipePkg::wordT aluM,
	output pipePkg::wordT storeDataM
);

	pipePkg::wordT srcA;
	pipePkg::wordT srcB;
	pipePkg::wordT sumE;
	pipePkg::wordT linkE;
	logic [DataWidth-1:0] aluReg;
	logic [DataWidth-1:0] storeReg;

	// operand muxes
	always_comb begin
		case (fwdA)
			pipePkg::fwdMem: srcA = aluM;
			pipePkg::fwdWb: srcA = resultW;
			default: srcA = opAE;
		endcase
		case (fwdB)
			pipePkg::fwdMem: srcB = aluM;
			pipePkg::fwdWb: srcB = resultW;
			default: srcB = opBE;
		endcase
	end

	// plain adds rs2, everything else adds imm
	assign sumE = srcA + ((cmdE == pipePkg::cmdPlain) ? srcB : immE);
	assign linkE = pcE + 32'd1;

	// not-taken prediction, so every jump redirects
	assign jumpTaken = (cmdE == pipePkg::cmdJump);
	assign jumpTarget = sumE;

	////////////////////
	// execute/memory register
	always_ff @(posedge clk) begin
		if (reset) begin
			cmdM <= pipePkg::cmdPlain;
			rdM <= '0;
			weM <= 1'b0;
		end else if (!stallAll) begin
			cmdM <= cmdE;
			rdM <= rdE;
			weM <= weE;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallAll) begin
			aluReg <= jumpTaken ? linkE : sumE;
			storeReg <= srcB;
		end
	end

	assign aluM = aluReg;
	assign storeDataM = storeReg;

endmodule

// File: logic/memWriteback.sv
`timescale 1ns/1ps
// memory and writeback stages
// drives the data port for loads and stores, keeps load data that
// arrives during a stall and writes each result to the register file once
module memWriteback #(
	parameter int DataWidth = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic stallAll,
	input  pipePkg::cmdT cmdM,
	input  pipePkg::regAddrT rdM,
	input  logic weM,
	input  pipePkg::wordT aluM,
	input  pipePkg::wordT storeDataM,
	output logic dataValid,
	output logic dataWrite,
	output pipePkg::wordT dataAddr,
	output pipePkg::wordT dataWdata,
	input  logic dataAck,
	input  pipePkg::wordT dataRdata,
	output logic dataPending,
	output pipePkg::cmdT cmdW,
	output pipePkg::regAddrT rdW,
	output logic weW,
	output pipePkg::wordT resultW,
	output logic regWrite,
	output pipePkg::regAddrT regWaddr,
	output pipePkg::wordT regWdata
);

	logic isMem;
	logic memDone;
	logic freshW;
	logic [DataWidth-1:0] loadBuf;
	logic [DataWidth-1:0] aluW;
	logic [DataWidth-1:0] loadW;

	////////////////////
	// data port
	assign isMem = (cmdM == pipePkg::cmdLoad) || (cmdM == pipePkg::cmdStore);
	// one transfer per instruction even if M is held afterwards
	assign dataValid = isMem && !memDone;
	assign dataPending = dataValid;
	assign dataWrite = (cmdM == pipePkg::cmdStore);
	assign dataAddr = aluM;
	assign dataWdata = storeDataM;

	always_ff @(posedge clk) begin
		if (reset) begin
			memDone <= 1'b0;
		end else if (!stallAll) begin
			memDone <= 1'b0;
		end else if (dataValid && dataAck) begin
			memDone <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dataValid && dataAck) begin
			loadBuf <= dataRdata;
		end
	end

	////////////////////
	// memory/writeback register
	always_ff @(posedge clk) begin
		if (reset) begin
			cmdW <= pipePkg::cmdPlain;
			rdW <= '0;
			weW <= 1'b0;
			freshW <= 1'b0;
		end else begin
			freshW <= !stallAll;
			if (!stallAll) begin
				cmdW <= cmdM;
				rdW <= rdM;
				weW <= weM;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stallAll) begin
			aluW <= aluM;
			loadW <= memDone ? loadBuf : dataRdata;
		end
	end

	assign resultW = (cmdW == pipePkg::cmdLoad) ? loadW : aluW;

	// W stays put during a stall for forwarding, but writes only once
	assign regWrite = weW && freshW;
	assign regWaddr = rdW;
	assign regWdata = resultW;

endmodule

// File: logic/pipeCore.sv
`timescale 1ns/1ps
// five-stage integer pipeline core
// fetch/decode, execute and memory/writeback stages around a hazard unit,
// with a valid/ack fetch port, a valid/ack data port and a retire port
// that mirrors the register file write
module pipeCore #(
	parameter int DataWidth = 32
) (
	input  logic clk,
	input  logic reset,
	output logic fetchValid,
	output pipePkg::wordT fetchAddr,
	input  logic fetchAck,
	input  pipePkg::instrT fetchInstr,
	output logic dataValid,
	output logic dataWrite,
	output pipePkg::wordT dataAddr,
	output pipePkg::wordT dataWdata,
	input  logic dataAck,
	input  pipePkg::wordT dataRdata,
	output logic retireValid,
	output pipePkg::regAddrT retireRd,
	output pipePkg::wordT retireData
);

	// decode
	pipePkg::cmdT cmdD;
	pipePkg::regAddrT rs1D;
	pipePkg::regAddrT rs2D;
	pipePkg::regAddrT rdAddrA;
	pipePkg::regAddrT rdAddrB;
	pipePkg::wordT rdDataA;
	pipePkg::wordT rdDataB;
	logic fetchPending;

	// execute
	pipePkg::cmdT cmdE;
	pipePkg::regAddrT rs1E;
	pipePkg::regAddrT rs2E;
	pipePkg::regAddrT rdE;
	logic weE;
	pipePkg::wordT opAE;
	pipePkg::wordT opBE;
	pipePkg::wordT immE;
	pipePkg::wordT pcE;
	logic jumpTaken;
	pipePkg::wordT jumpTarget;

	// memory and writeback
	pipePkg::cmdT cmdM;
	pipePkg::regAddrT rdM;
	logic weM;
	pipePkg::wordT aluM;
	pipePkg::wordT storeDataM;
	logic dataPending;
	pipePkg::regAddrT rdW;
	logic weW;
	pipePkg::wordT resultW;

	// hazard control
	pipePkg::fwdSelT fwdA;
	pipePkg::fwdSelT fwdB;
	logic stallAll;
	logic bubbleE;
	logic flushD;

	fetchDecode fetchDecode_inst (
		.clk(clk), .reset(reset),
		.fetchValid(fetchValid), .fetchAddr(fetchAddr),
		.fetchAck(fetchAck), .fetchInstr(fetchInstr),
		.stallAll(stallAll), .bubbleE(bubbleE), .flushD(flushD),
		.jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
		.cmdD(cmdD), .rs1D(rs1D), .rs2D(rs2D), .rdD(),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.cmdE(cmdE), .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .weE(weE),
		.opAE(opAE), .opBE(opBE), .immE(immE), .pcE(pcE),
		.fetchPending(fetchPending)
	);

	executeStage #(.DataWidth(DataWidth)) executeStage_inst (
		.clk(clk), .reset(reset), .stallAll(stallAll),
		.cmdE(cmdE), .rdE(rdE), .weE(weE),
		.opAE(opAE), .opBE(opBE), .immE(immE), .pcE(pcE),
		.fwdA(fwdA), .fwdB(fwdB), .resultW(resultW),
		.jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
		.cmdM(cmdM), .rdM(rdM), .weM(weM),
		.aluM(aluM), .storeDataM(storeDataM)
	);

	memWriteback #(.DataWidth(DataWidth)) memWriteback_inst (
		.clk(clk), .reset(reset), .stallAll(stallAll),
		.cmdM(cmdM), .rdM(rdM), .weM(weM),
		.aluM(aluM), .storeDataM(storeDataM),
		.dataValid(dataValid), .dataWrite(dataWrite),
		.dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataAck(dataAck), .dataRdata(dataRdata),
		.dataPending(dataPending),
		.cmdW(), .rdW(rdW), .weW(weW), .resultW(resultW),
		.regWrite(retireValid), .regWaddr(retireRd), .regWdata(retireData)
	);

	hazardUnit hazardUnit_inst (
		.clk(clk), .reset(reset),
		.cmdD(cmdD), .rs1D(rs1D), .rs2D(rs2D),
		.cmdE(cmdE), .rdE(rdE), .rs1E(rs1E), .rs2E(rs2E),
		.cmdM(cmdM), .rdM(rdM), .weM(weM),
		.rdW(rdW), .weW(weW),
		.jumpTaken(jumpTaken), .fetchPending(fetchPending),
		.dataPending(dataPending), .dataAck(dataAck),
		.fwdA(fwdA), .fwdB(fwdB),
		.stallAll(stallAll), .bubbleE(bubbleE), .flushD(flushD)
	);

	// retire port doubles as the register write port
	regFile #(.DataWidth(DataWidth)) regFile_inst (
		.clk(clk), .reset(reset),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(retireValid), .wrAddr(retireRd), .wrData(retireData)
	);

endmodule

// File: test/dataMemModel.sv
`timescale 1ns/1ps
// data memory model for the pipeline testbench
// 256 words behind the valid/ack data port, acks after a random wait,
// and checks that a request is held unchanged until its ack
module dataMemModel (
	input  logic clk,
	input  logic reset,
	input  logic dataValid,
	input  logic dataWrite,
	input  pipePkg::wordT dataAddr,
	input  pipePkg::wordT dataWdata,
	output logic dataAck,
	output pipePkg::wordT dataRdata,
	output int holdErrors
);

	pipePkg::wordT mem [256];
	int ackWait;
	logic waiting;
	logic savedWrite;
	pipePkg::wordT savedAddr;
	pipePkg::wordT savedWdata;

	// every word differs, spread over the whole address
	function automatic pipePkg::wordT fillWord(input int a);
		return 32'h9E3779B9 * (a + 1);
	endfunction

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = fillWord(i);
		end
		dataAck = 1'b0;
		dataRdata = '0;
		holdErrors = 0;
		waiting = 1'b0;
		ackWait = 0;
	end

	////////////////////
	// responder
	always @(posedge clk) begin
		if (reset) begin
			dataAck <= 1'b0;
			ackWait <= $urandom % 4;
		end else if (dataValid && !dataAck) begin
			if (ackWait == 0) begin
				dataAck <= 1'b1;
				dataRdata <= mem[dataAddr[7:0]];
			end else begin
				ackWait <= ackWait - 1;
			end
		end else begin
			dataAck <= 1'b0;
			ackWait <= $urandom % 4;
			// store lands in the ack cycle
			if (dataValid && dataAck && dataWrite) begin
				mem[dataAddr[7:0]] <= dataWdata;
			end
		end
	end

	////////////////////
	// hold-until-ack check
	always @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
		end else begin
			if (waiting) begin
				assert (dataValid && dataWrite == savedWrite && dataAddr == savedAddr
					&& (!savedWrite || dataWdata == savedWdata)) else begin
					holdErrors++;
					$display("data request changed or dropped before its ack at %0t", $time);
				end
			end
			waiting <= dataValid && !dataAck;
			savedWrite <= dataWrite;
			savedAddr <= dataAddr;
			savedWdata <= dataWdata;
		end
	end

endmodule

// File: test/pipeCoreTb.sv
`timescale 1ns/1ps
// testbench for the pipeline core
// runs a fixed program from a ROM with random fetch and data latency,
// replays it on a reference interpreter and checks every retire in order
module pipeCoreTb;

	localparam int progLen = 27;
	localparam int timeoutCycles = 40 * progLen;
	localparam int drainCycles = 20;

	logic clk = 1'b0;
	logic reset;
	logic fetchValid;
	pipePkg::wordT fetchAddr;
	logic fetchAck;
	pipePkg::instrT fetchInstr;
	logic dataValid;
	logic dataWrite;
	pipePkg::wordT dataAddr;
	pipePkg::wordT dataWdata;
	logic dataAck;
	pipePkg::wordT dataRdata;
	logic retireValid;
	pipePkg::regAddrT retireRd;
	pipePkg::wordT retireData;

	pipePkg::instrT prog [progLen];
	pipePkg::regAddrT expRd [$];
	pipePkg::wordT expData [$];
	int fetchWait;
	int cycleCount;
	int retireCount;
	int expCount;
	int errorCount;
	int memErrors;
	logic timedOut;
	logic firstFetchSeen;

	pipeCore #(.DataWidth(32)) pipeCore_inst (
		.clk(clk), .reset(reset),
		.fetchValid(fetchValid), .fetchAddr(fetchAddr),
		.fetchAck(fetchAck), .fetchInstr(fetchInstr),
		.dataValid(dataValid), .dataWrite(dataWrite),
		.dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataAck(dataAck), .dataRdata(dataRdata),
		.retireValid(retireValid), .retireRd(retireRd), .retireData(retireData)
	);

	dataMemModel dataMemModel_inst (
		.clk(clk), .reset(reset),
		.dataValid(dataValid), .dataWrite(dataWrite),
		.dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataAck(dataAck), .dataRdata(dataRdata),
		.holdErrors(memErrors)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	function automatic pipePkg::instrT encode(input pipePkg::cmdT cmd, input int rd,
		input int rs1, input int rs2, input int imm);
		return {cmd, rd[4:0], rs1[4:0], rs2[4:0], imm[14:0]};
	endfunction

	// same fill as the data memory model
	function automatic pipePkg::wordT fillWord(input int a);
		return 32'h9E3779B9 * (a + 1);
	endfunction

	// past the end of the program sits a jump to itself
	function automatic pipePkg::instrT romWord(input pipePkg::wordT addr);
		pipePkg::instrT w;
		w = encode(pipePkg::cmdJump, 0, 0, 0, progLen);
		if (addr < progLen) begin
			w = prog[addr];
		end
		return w;
	endfunction

	////////////////////
	// program
	task automatic loadProgram();
		prog[0] = encode(pipePkg::cmdLoad, 1, 0, 0, 5);
		prog[1] = encode(pipePkg::cmdLoad, 2, 0, 0, 9);
		// load-use then chains fed from M and W
		prog[2] = encode(pipePkg::cmdPlain, 3, 1, 2, 0);
		prog[3] = encode(pipePkg::cmdPlain, 4, 3, 1, 0);
		prog[4] = encode(pipePkg::cmdPlain, 5, 4, 3, 0);
		prog[5] = encode(pipePkg::cmdPlain, 6, 5, 5, 0);
		prog[6] = encode(pipePkg::cmdStore, 0, 0, 6, 20);
		prog[7] = encode(pipePkg::cmdLoad, 7, 0, 0, 20);
		prog[8] = encode(pipePkg::cmdPlain, 8, 7, 1, 0);
		prog[9] = encode(pipePkg::cmdStore, 0, 0, 8, -3);
		prog[10] = encode(pipePkg::cmdLoad, 9, 0, 0, -3);
		prog[11] = encode(pipePkg::cmdPlain, 10, 9, 9, 0);
		// jump with link and two wrong-path instructions behind it
		prog[12] = encode(pipePkg::cmdJump, 11, 0, 0, 15);
		prog[13] = encode(pipePkg::cmdPlain, 12, 1, 1, 0);
		prog[14] = encode(pipePkg::cmdPlain, 13, 2, 2, 0);
		prog[15] = encode(pipePkg::cmdPlain, 14, 11, 10, 0);
		prog[16] = encode(pipePkg::cmdJump, 0, 0, 0, 19);
		prog[17] = encode(pipePkg::cmdPlain, 12, 1, 2, 0);
		prog[18] = encode(pipePkg::cmdPlain, 13, 3, 4, 0);
		prog[19] = encode(pipePkg::cmdPlain, 17, 14, 6, 0);
		prog[20] = encode(pipePkg::cmdPlain, 0, 17, 17, 0);
		prog[21] = encode(pipePkg::cmdPlain, 18, 0, 17, 0);
		prog[22] = encode(pipePkg::cmdStore, 0, 0, 18, 40);
		prog[23] = encode(pipePkg::cmdLoad, 19, 0, 0, 40);
		prog[24] = encode(pipePkg::cmdStore, 0, 0, 19, 41);
		prog[25] = encode(pipePkg::cmdLoad, 20, 0, 0, 41);
		prog[26] = encode(pipePkg::cmdPlain, 21, 20, 19, 0);
	endtask

	// reference interpreter that builds the expected register writes
	task automatic runReference();
		pipePkg::wordT regs [32];
		pipePkg::wordT mem [256];
		pipePkg::wordT pc;
		pipePkg::wordT a;
		pipePkg::wordT b;
		pipePkg::wordT immVal;
		pipePkg::wordT addr;
		pipePkg::wordT value;
		pipePkg::wordT nextPc;
		pipePkg::instrT ins;
		pipePkg::regAddrT rd;
		logic doWrite;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = fillWord(i);
		end
		pc = '0;
		steps = 0;
		while (pc < progLen && steps < 1000) begin
			ins = prog[pc];
			rd = ins[29:25];
			a = regs[ins[24:20]];
			b = regs[ins[19:15]];
			immVal = {{17{ins[14]}}, ins[14:0]};
			addr = a + immVal;
			nextPc = pc + 1;
			value = '0;
			doWrite = 1'b1;
			case (ins[31:30])
				pipePkg::cmdPlain: value = a + b;
				pipePkg::cmdLoad: value = mem[addr[7:0]];
				pipePkg::cmdStore: begin
					mem[addr[7:0]] = b;
					doWrite = 1'b0;
				end
				default: begin
					value = pc + 1;
					nextPc = addr;
				end
			endcase
			if (doWrite && rd != 0) begin
				regs[rd] = value;
				expRd.push_back(rd);
				expData.push_back(value);
			end
			pc = nextPc;
			steps++;
		end
	endtask

	////////////////////
	// fetch responder
	always @(posedge clk) begin
		if (reset) begin
			fetchAck <= 1'b0;
			fetchWait <= $urandom % 4;
		end else if (fetchValid && !fetchAck) begin
			if (fetchWait == 0) begin
				fetchAck <= 1'b1;
				fetchInstr <= romWord(fetchAddr);
			end else begin
				fetchWait <= fetchWait - 1;
			end
		end else begin
			fetchAck <= 1'b0;
			fetchWait <= $urandom % 4;
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			cycleCount++;
			if (cycleCount >= timeoutCycles && retireCount < expCount) begin
				timedOut <= 1'b1;
			end
		end
	end

	////////////////////
	// checks
	task automatic checkRetire();
		assert (expRd.size() != 0) else begin
			errorCount++;
			$display("r%0d retired at %0t after the program had finished", retireRd, $time);
		end
		if (expRd.size() != 0) begin
			assert (retireRd == expRd[0] && retireData == expData[0]) else begin
				errorCount++;
				$display("MISMATCH at %0t: retire %0d expected r%0d = %h, got r%0d = %h",
					$time, retireCount, expRd[0], expData[0], retireRd, retireData);
			end
			void'(expRd.pop_front());
			void'(expData.pop_front());
			retireCount++;
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			assert (!fetchValid && !dataValid && !retireValid) else begin
				errorCount++;
				$display("core port active during reset at %0t", $time);
			end
		end else begin
			if (fetchValid && !firstFetchSeen) begin
				firstFetchSeen = 1'b1;
				assert (fetchAddr == '0) else begin
					errorCount++;
					$display("MISMATCH at %0t: first fetch address expected 0, got %h",
						$time, fetchAddr);
				end
			end
			if (retireValid) begin
				checkRetire();
			end
		end
	end

	initial begin
		fetchWait = $urandom(20568) % 4;
		reset = 1'b1;
		fetchAck = 1'b0;
		fetchInstr = '0;
		cycleCount = 0;
		retireCount = 0;
		errorCount = 0;
		timedOut = 1'b0;
		firstFetchSeen = 1'b0;
		loadProgram();
		runReference();
		expCount = expRd.size();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		while (retireCount < expCount && !timedOut) begin
			@(posedge clk);
		end
		// late retires from wrong-path work would show up here
		if (!timedOut) begin
			repeat (drainCycles) @(posedge clk);
		end else begin
			$display("timeout after %0d cycles, %0d of %0d writes retired",
				cycleCount, retireCount, expCount);
		end
		$display("errors: %0d core, %0d data port; retired %0d of %0d",
			errorCount, memErrors, retireCount, expCount);
		if (errorCount == 0 && memErrors == 0 && !timedOut) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
logic/pipePkg.sv
logic/hazardUnit.sv
logic/regFile.sv
logic/fetchDecode.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/pipeCore.sv
test/dataMemModel.sv
test/pipeCoreTb.sv
